/* src.f */
source/writeback_pkg.sv
source/activation_clamp.sv
source/output_alignment_padding.sv
source/row_writer.sv
source/host_reader.sv
source/memory_arbiter.sv
source/feature_map_ram.sv
source/writeback_top.sv
test/writeback_chk.sv
test/writeback_tb.sv

/* run.sh */
#!/bin/sh
# builds the writeback testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module writeback_tb -f src.f -o Vwriteback_tb

status=0
./obj_dir/Vwriteback_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

/* test/writeback_tb.sv */
`timescale 1ns/1ps

module writeback_tb;
	import writeback_pkg::*;

	localparam int ADDR_W = 6;
	localparam int DEPTH = 1 << ADDR_W;
	localparam int RESET_CYCLES = 4;
	localparam int CLAMP_ROWS = 20;
	localparam int LEFT_ROWS = 16;
	localparam int RIGHT_ROWS = 10;
	localparam int TILE_ROWS = 6;
	localparam int BURST_ROWS = 24;
	localparam int GAP_ROWS = 6;
	localparam int TILE_PULSES = 2;
	localparam int SINGLE_ROWS = CLAMP_ROWS + LEFT_ROWS + RIGHT_ROWS + TILE_ROWS + GAP_ROWS;
	localparam int READS = CLAMP_ROWS + LEFT_ROWS + RIGHT_ROWS + TILE_ROWS + 1
		+ TILE_ROWS + BURST_ROWS + GAP_ROWS;
	localparam int STIM_CYCLES = RESET_CYCLES + 2 * SINGLE_ROWS + BURST_ROWS + 1
		+ 3 * TILE_PULSES + 3 * READS;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

	logic              clk;
	logic              reset;
	acc_row_t          in_row;
	logic              in_valid;
	logic [4:0]        shift;
	logic [PAD_W-1:0]  pad_left;
	logic [PAD_W-1:0]  pad_right;
	logic              tile_start;
	logic              rd_req;
	logic [ADDR_W-1:0] rd_addr;
	act_row_t          rd_data;
	logic              rd_valid;

	integer   seed = 58089;
	act_row_t ring_m [N_DIM]; // expected ring of unpadded rows.
	int       ring_ptr_m;
	int       wr_addr_m;
	act_row_t exp_mem [DEPTH];
	int       cycle_count;

	writeback_top #(.ADDR_W(ADDR_W)) dut (
		.clk        (clk),
		.reset      (reset),
		.in_row     (in_row),
		.in_valid   (in_valid),
		.shift      (shift),
		.pad_left   (pad_left),
		.pad_right  (pad_right),
		.tile_start (tile_start),
		.rd_req     (rd_req),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout reached after %0d cycles without finishing", cycle_count);
		$display("Test FAILED");
		$fatal(1, "run stopped by the cycle limit");
	end

	// a failed bound assertion ends the run on the next falling edge.
	always @(negedge clk) begin
		if (dut.chk.fail_count != 0) begin
			$display("a bound protocol assertion failed before %0t ns", $time);
			$display("Test FAILED");
			$fatal(1, "stopping at the first error");
		end
	end

	// lanes mix large positives, negatives, small values and full-range noise.
	function automatic acc_t random_lane();
		int kind;
		kind = $random(seed) & 3;
		case (kind)
			0: return acc_t'(32'h0040_0000 | ($random(seed) & 32'h003f_ffff));
			1: return acc_t'(-(($random(seed) & 32'h000f_ffff) + 1));
			2: return acc_t'($random(seed) & 32'h0000_0fff);
			default: return acc_t'($random(seed));
		endcase
	endfunction

	function automatic acc_row_t random_row();
		acc_row_t row;
		for (int i = 0; i < N_DIM; i++)
			row[i] = random_lane();
		return row;
	endfunction

	function automatic act_t relu_saturate(acc_t lane, int sh);
		acc_t scaled;
		scaled = lane >>> sh;
		if (scaled < 0)
			return '0;
		if (scaled > 127)
			return 8'sd127;
		return act_t'(scaled);
	endfunction

	function automatic act_row_t align_row(act_row_t cur, act_row_t old, int pl, int pr);
		act_row_t row;
		for (int i = 0; i < N_DIM; i++) begin
			if (i >= N_DIM - pr)
				row[i] = '0;
			else if (i < pl)
				row[i] = old[N_DIM - pl + i]; // tail of the row from N_DIM rows back.
			else
				row[i] = cur[i - pl];
		end
		return row;
	endfunction

	task automatic predict_row(input acc_row_t row, input int sh, input int pl, input int pr);
		act_row_t act;
		for (int i = 0; i < N_DIM; i++)
			act[i] = relu_saturate(row[i], sh);
		exp_mem[wr_addr_m] = align_row(act, ring_m[ring_ptr_m], pl, pr);
		ring_m[ring_ptr_m] = act;
		ring_ptr_m = (ring_ptr_m + 1) % N_DIM;
		wr_addr_m = (wr_addr_m + 1) % DEPTH;
	endtask

	// pad settings stay put until the row has passed the alignment stage.
	task automatic send_row(input int sh, input int pl, input int pr, input bit gap);
		acc_row_t row;
		row = random_row();
		@(negedge clk);
		in_row = row;
		in_valid = 1'b1;
		shift = sh[4:0];
		pad_left = pl[PAD_W-1:0];
		pad_right = pr[PAD_W-1:0];
		predict_row(row, sh, pl, pr);
		if (gap) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic pulse_tile_start();
		@(negedge clk);
		in_valid = 1'b0;
		@(negedge clk);
		tile_start = 1'b1;
		for (int r = 0; r < N_DIM; r++)
			ring_m[r] = '0;
		wr_addr_m = 0; // the ring pointer keeps running.
		@(negedge clk);
		tile_start = 1'b0;
	endtask

	task automatic check_row(input int addr, input act_row_t got, input act_row_t exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: row %0d read %h, expected %h", $time, addr, got, exp);
			$display("Test FAILED");
			$fatal(1, "stopping at the first error");
		end
	endtask

	task automatic await_read(input int addr);
		do
			@(negedge clk);
		while (!rd_valid);
		check_row(addr, rd_data, exp_mem[addr]);
	endtask

	task automatic read_and_check(input int addr);
		@(negedge clk);
		rd_req = 1'b1;
		rd_addr = addr[ADDR_W-1:0];
		@(negedge clk);
		rd_req = 1'b0;
		await_read(addr);
	endtask

	task automatic read_range(input int first, input int count);
		for (int i = 0; i < count; i++)
			read_and_check((first + i) % DEPTH);
	endtask

	// back-to-back rows keep the writer busy, so the read waits for the end.
	task automatic write_burst(input int read_addr);
		for (int i = 0; i < BURST_ROWS; i++) begin
			send_row(6, 2, 1, 1'b0);
			rd_req = (i == 3);
			rd_addr = read_addr[ADDR_W-1:0];
		end
		@(negedge clk);
		in_valid = 1'b0;
		await_read(read_addr);
	endtask

	initial begin
		in_row = '0;
		in_valid = 1'b0;
		shift = '0;
		pad_left = '0;
		pad_right = '0;
		tile_start = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		reset = 1'b0;
		ring_ptr_m = 0;
		wr_addr_m = 0;
		for (int r = 0; r < N_DIM; r++)
			ring_m[r] = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b1;

		for (int i = 0; i < CLAMP_ROWS; i++)
			send_row((i * 5) % 24, 0, 0, 1'b1);
		read_range(0, CLAMP_ROWS);

		pulse_tile_start();
		for (int i = 0; i < LEFT_ROWS; i++)
			send_row(6, 1 + i % 7, 0, 1'b1);
		read_range(0, LEFT_ROWS);

		for (int i = 0; i < RIGHT_ROWS; i++)
			send_row(6, i % 4, 1 + i % 7, 1'b1);
		read_range(LEFT_ROWS, RIGHT_ROWS);

		// the ring was full of nonzero rows, so the low lanes show the clear.
		pulse_tile_start();
		for (int i = 0; i < TILE_ROWS; i++)
			send_row(4, 3 + i % 5, 0, 1'b1);
		read_range(0, TILE_ROWS);

		write_burst(0);
		read_range(0, TILE_ROWS + BURST_ROWS);

		for (int i = 0; i < GAP_ROWS; i++) begin
			send_row(5, i % 8, i % 3, 1'b1);
			read_and_check((wr_addr_m + DEPTH - 1) % DEPTH);
		end

		if (dut.chk.fail_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* test/writeback_chk.sv */
`timescale 1ns/1ps

module writeback_chk (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    rd_req,
	input  logic                    rd_valid,
	input  logic                    rd_grant,
	input  writeback_pkg::mem_req_t wr_req,
	input  writeback_pkg::mem_req_t rd_mreq,
	input  writeback_pkg::mem_req_t ram_req
);

	int fail_count = 0; // watched by the testbench on every cycle.

	// the earliest answer is two edges after the request.
	a_rd_valid_late: assert property (@(posedge clk) disable iff (!reset)
		rd_req |=> !rd_valid)
		else begin
			$error("rd_valid arrived one cycle after rd_req");
			fail_count++;
		end

	// rd_mreq.valid is the pending flag of the host reader.
	a_no_req_while_pending: assert property (@(posedge clk) disable iff (!reset)
		rd_req |-> !rd_mreq.valid)
		else begin
			$error("rd_req raised while a read was still pending");
			fail_count++;
		end

	// a granted read has the RAM port to itself.
	a_no_write_grant_overlap: assert property (@(posedge clk) disable iff (!reset)
		rd_grant |-> !wr_req.valid && ram_req.valid && !ram_req.write)
		else begin
			$error("read grant overlapped a write or did not reach the RAM port");
			fail_count++;
		end

	a_rd_valid_reset: assert property (@(posedge clk) !reset |-> !rd_valid)
		else begin
			$error("rd_valid high during reset");
			fail_count++;
		end

endmodule

bind writeback_top writeback_chk chk (
	.clk      (clk),
	.reset    (reset),
	.rd_req   (rd_req),
	.rd_valid (rd_valid),
	.rd_grant (rd_grant),
	.wr_req   (wr_req),
	.rd_mreq  (rd_mreq),
	.ram_req  (ram_req)
);

/* source/writeback_top.sv */
`timescale 1ns/1ps

module writeback_top #(
	parameter int ADDR_W = 6
) (
	input  logic                            clk,
	input  logic                            reset,
	input  writeback_pkg::acc_row_t         in_row,
	input  logic                            in_valid,
	input  logic [4:0]                      shift,
	input  logic [writeback_pkg::PAD_W-1:0] pad_left,
	input  logic [writeback_pkg::PAD_W-1:0] pad_right,
	input  logic                            tile_start,
	input  logic                            rd_req,
	input  logic [ADDR_W-1:0]               rd_addr,
	output writeback_pkg::act_row_t         rd_data,
	output logic                            rd_valid
);
	import writeback_pkg::*;

	act_row_t act_row;
	logic     act_valid;
	act_row_t pad_row;
	logic     pad_valid;
	mem_req_t wr_req;
	mem_req_t rd_mreq;
	mem_req_t ram_req;
	logic     rd_grant;
	act_row_t ram_rdata;

	activation_clamp u_clamp (
		.clk       (clk),
		.reset     (reset),
		.in_row    (in_row),
		.in_valid  (in_valid),
		.shift     (shift),
		.act_row   (act_row),
		.act_valid (act_valid)
	);

	output_alignment_padding u_align (
		.clk                  (clk),
		.reset                (reset),
		.reinitialize_padding (tile_start),
		.pad_left             (pad_left),
		.pad_right            (pad_right),
		.act_row              (act_row),
		.act_valid            (act_valid),
		.pad_row              (pad_row),
		.pad_valid            (pad_valid)
	);

	row_writer #(.ADDR_W(ADDR_W)) u_writer (
		.clk        (clk),
		.reset      (reset),
		.tile_start (tile_start),
		.pad_row    (pad_row),
		.pad_valid  (pad_valid),
		.wr_req     (wr_req)
	);

	host_reader #(.ADDR_W(ADDR_W)) u_reader (
		.clk       (clk),
		.reset     (reset),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_grant  (rd_grant),
		.mem_rdata (ram_rdata),
		.rd_mreq   (rd_mreq),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid)
	);

	memory_arbiter #(.ADDR_W(ADDR_W)) u_arbiter (
		.clk      (clk),
		.reset    (reset),
		.wr_req   (wr_req),
		.rd_mreq  (rd_mreq),
		.ram_req  (ram_req),
		.rd_grant (rd_grant)
	);

	feature_map_ram #(.ADDR_W(ADDR_W)) u_ram (
		.clk       (clk),
		.ram_req   (ram_req),
		.ram_rdata (ram_rdata)
	);

endmodule

/* source/feature_map_ram.sv */
`timescale 1ns/1ps

module feature_map_ram #(
	parameter int ADDR_W = 6
) (
	input  logic                    clk,
	input  writeback_pkg::mem_req_t ram_req,
	output writeback_pkg::act_row_t ram_rdata
);
	import writeback_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	act_row_t          mem [DEPTH];
	logic [ADDR_W-1:0] addr;

	assign addr = ram_req.addr[ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (ram_req.valid) begin
			if (ram_req.write)
				mem[addr] <= ram_req.wdata;
			else
				ram_rdata <= mem[addr]; // read data only changes on a read.
		end
	end

endmodule

/* source/memory_arbiter.sv */
`timescale 1ns/1ps

module memory_arbiter #(
	parameter int ADDR_W = 6
) (
	input  logic                    clk,
	input  logic                    reset,
	input  writeback_pkg::mem_req_t wr_req,
	input  writeback_pkg::mem_req_t rd_mreq,
	output writeback_pkg::mem_req_t ram_req,
	output logic                    rd_grant
);
	import writeback_pkg::*;

	mem_owner_e owner;
	mem_owner_e owner_next;
	mem_req_t   sel_req;

	// the writer is never held off, so the reader only gets idle cycles.
	assign rd_grant = rd_mreq.valid && !wr_req.valid && (owner != OWNER_READER);

	always_comb begin
		if (wr_req.valid) begin
			sel_req = wr_req;
			owner_next = OWNER_WRITER;
		end else if (rd_grant) begin
			sel_req = rd_mreq;
			owner_next = OWNER_READER;
		end else begin
			sel_req = '0;
			owner_next = OWNER_NONE;
		end
	end

	always_comb begin
		ram_req = sel_req;
		ram_req.addr = REQ_ADDR_W'(sel_req.addr[ADDR_W-1:0]); // only the RAM depth is decoded.
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			owner <= OWNER_NONE;
		else
			owner <= owner_next;
	end

endmodule

/* source/host_reader.sv */
`timescale 1ns/1ps

module host_reader #(
	parameter int ADDR_W = 6
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    rd_req,
	input  logic [ADDR_W-1:0]       rd_addr,
	input  logic                    rd_grant,
	input  writeback_pkg::act_row_t mem_rdata,
	output writeback_pkg::mem_req_t rd_mreq,
	output writeback_pkg::act_row_t rd_data,
	output logic                    rd_valid
);
	import writeback_pkg::*;

	logic              pending;
	logic [ADDR_W-1:0] pend_addr;
	act_row_t          data_q;

	always_comb begin
		rd_mreq.valid = pending;
		rd_mreq.write = 1'b0;
		rd_mreq.addr = REQ_ADDR_W'(pend_addr);
		rd_mreq.wdata = '0;
	end

	// the fresh RAM word is shown during rd_valid and held afterwards.
	assign rd_data = rd_valid ? mem_rdata : data_q;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pending <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_grant; // the RAM registers the row on the grant edge.
			if (rd_req)
				pending <= 1'b1;
			else if (rd_grant)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_req)
			pend_addr <= rd_addr;
		if (rd_valid)
			data_q <= mem_rdata;
	end

endmodule

/* source/row_writer.sv */
`timescale 1ns/1ps

module row_writer #(
	parameter int ADDR_W = 6
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    tile_start,
	input  writeback_pkg::act_row_t pad_row,
	input  logic                    pad_valid,
	output writeback_pkg::mem_req_t wr_req
);
	import writeback_pkg::*;

	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] cur_addr;

	assign cur_addr = tile_start ? '0 : wr_addr; // a new tile writes its first row at zero.

	always_comb begin
		wr_req.valid = pad_valid;
		wr_req.write = 1'b1;
		wr_req.addr = REQ_ADDR_W'(cur_addr);
		wr_req.wdata = pad_row;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			wr_addr <= '0;
		else if (pad_valid)
			wr_addr <= cur_addr + 1'b1; // wraps at the RAM depth.
		else if (tile_start)
			wr_addr <= '0;
	end

endmodule

/* source/output_alignment_padding.sv */
`timescale 1ns/1ps

module output_alignment_padding (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            reinitialize_padding,
	input  logic [writeback_pkg::PAD_W-1:0] pad_left,
	input  logic [writeback_pkg::PAD_W-1:0] pad_right,
	input  writeback_pkg::act_row_t         act_row,
	input  logic                            act_valid,
	output writeback_pkg::act_row_t         pad_row,
	output logic                            pad_valid
);
	import writeback_pkg::*;

	act_row_t         ring [N_DIM];
	logic [PTR_W-1:0] ring_ptr;
	act_row_t         old_row;

	assign old_row = ring[ring_ptr]; // the entry at the pointer was stored N_DIM rows ago.
	assign pad_valid = act_valid;

	always_comb begin
		for (int i = 0; i < N_DIM; i++) begin
			if (i < int'(pad_left))
				pad_row[i] = old_row[N_DIM - int'(pad_left) + i];
			else
				pad_row[i] = act_row[i - int'(pad_left)];
			if (N_DIM - i <= int'(pad_right))
				pad_row[i] = '0; // right padding overrides whatever landed in the top lanes.
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			ring_ptr <= '0;
		else if (act_valid)
			ring_ptr <= ring_ptr + 1'b1; // keeps running across a reinitialize.
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int r = 0; r < N_DIM; r++)
				ring[r] <= '0;
		end else if (reinitialize_padding) begin
			for (int r = 0; r < N_DIM; r++)
				ring[r] <= '0;
		end else if (act_valid) begin
			ring[ring_ptr] <= act_row;
		end
	end

endmodule

/* source/activation_clamp.sv */
`timescale 1ns/1ps

module activation_clamp (
	input  logic                    clk,
	input  logic                    reset,
	input  writeback_pkg::acc_row_t in_row,
	input  logic                    in_valid,
	input  logic [4:0]              shift,
	output writeback_pkg::act_row_t act_row,
	output logic                    act_valid
);
	import writeback_pkg::*;

	acc_row_t shifted;
	act_row_t clamped;

	// per lane: arithmetic shift, then ReLU and saturation to ACT_W bits.
	always_comb begin
		for (int i = 0; i < N_DIM; i++) begin
			shifted[i] = in_row[i] >>> shift;
			if (shifted[i] < 0)
				clamped[i] = '0;
			else if (shifted[i] > ACT_MAX)
				clamped[i] = ACT_W'(ACT_MAX); // saturate large positives.
			else
				clamped[i] = shifted[i][ACT_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			act_valid <= 1'b0;
		else
			act_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			act_row <= clamped; // the row holds between strobes.
	end

endmodule

/* source/writeback_pkg.sv */
package writeback_pkg;

	localparam int N_DIM = 8;
	localparam int ACT_W = 8;
	localparam int ACC_W = 24;
	localparam int PAD_W = 3;

	localparam int PTR_W = $clog2(N_DIM); // ring pointer over N_DIM stored rows.
	localparam int REQ_ADDR_W = 16;
	localparam int ACT_MAX = (1 << (ACT_W - 1)) - 1; // largest positive activation.

	// one signed lane of each kind, so that indexing a row yields a signed value.
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic signed [ACT_W-1:0] act_t;

	typedef acc_t [N_DIM-1:0] acc_row_t;
	typedef act_t [N_DIM-1:0] act_row_t; // lane 0 sits at the low end.

	typedef struct packed {
		logic                  valid;
		logic                  write;
		logic [REQ_ADDR_W-1:0] addr;
		act_row_t              wdata;
	} mem_req_t;

	typedef enum logic [1:0] {
		OWNER_NONE,
		OWNER_WRITER,
		OWNER_READER
	} mem_owner_e;

endpackage
